//--- rtl/eth_rx_pkg.sv
/* Shared widths, lock thresholds and block types for the four-port 10GBASE-R
   receive path. Modules reach these through eth_rx_pkg:: scoped names */
package eth_rx_pkg;

	////////////////////
	// Port and data widths
	////////////////////
	localparam int NUM_PORTS = 4;
	localparam int WORD_W = 64;
	localparam int BLOCK_W = 66;
	localparam int LANE_IDX_W = 2;

	// Gearbox accumulator, two blocks less the final pair
	localparam int GEAR_W = 2 * BLOCK_W - 2;
	// Fill count in bit pairs, up to a full word of pairs plus one block
	localparam int GEAR_CNT_W = 7;
	localparam logic [GEAR_CNT_W-1:0] GEAR_ADD = GEAR_CNT_W'(WORD_W / 2);
	localparam logic [GEAR_CNT_W-1:0] GEAR_FULL = GEAR_CNT_W'(BLOCK_W / 2);

	// Slip offset 0 .. BLOCK_W-1
	localparam int SLIP_W = 7;
	localparam logic [SLIP_W-1:0] SLIP_LAST = SLIP_W'(BLOCK_W - 1);

	////////////////////
	// Lock hysteresis
	////////////////////
	localparam int LOCK_CNT_W = 4;
	localparam logic [LOCK_CNT_W-1:0] LOCK_MAX = 4'd15;
	localparam logic [LOCK_CNT_W-1:0] LOCK_PENALTY = 4'd3;
	// Counter at 8 or more means locked
	localparam int LOCK_BIT = 3;

	// Descrambler taps for x^58 + x^39 + 1
	localparam int SCR_TAP_A = 39;
	localparam int SCR_TAP_B = 58;

	// Header bit 0 is the first bit on the wire
	typedef struct packed
	{
		logic [1:0] hdr;
		logic [WORD_W-1:0] payload;
	} rx_block_t;

	// Entry p holds the physical lane feeding logical port p
	typedef logic [NUM_PORTS-1:0][LANE_IDX_W-1:0] lane_map_t;

endpackage

//--- rtl/rx_lane_remap.sv
/* Registered lane crossbar. Routes each physical serdes lane to its logical
   port and inverts lanes whose wiring swaps the differential pair */
`timescale 1ns/1ns

module rx_lane_remap
(
	input logic i_clk,
	input logic i_reset,
	input logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] i_serdes,
	input eth_rx_pkg::lane_map_t i_lane_map,
	input logic [eth_rx_pkg::NUM_PORTS-1:0] i_polarity,
	output logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] o_words
);

	// Selected lane per port, before the register
	logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] sel_words;

	////////////////////
	// Lane select
	////////////////////
	always_comb
	begin
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			// Polarity belongs to the physical lane, not the port
			sel_words[p] = i_serdes[i_lane_map[p]]
				^ {eth_rx_pkg::WORD_W{i_polarity[i_lane_map[p]]}};
		end
	end

	////////////////////
	// Output register
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_words <= '0;
		end
		else
		begin
			// Map and polarity are quasi-static, no hold-off on change
			o_words <= sel_words;
		end
	end

endmodule

//--- rtl/rx_gearbox_align.sv
/* One port's 64-to-66 gearbox and block aligner. Hunts for valid sync
   headers by slipping one bit at a time and holds lock with hysteresis */
`timescale 1ns/1ns

module rx_gearbox_align
(
	input logic i_clk,
	input logic i_reset,
	input logic [eth_rx_pkg::WORD_W-1:0] i_word,
	output logic o_valid,
	output eth_rx_pkg::rx_block_t o_block,
	output logic o_locked
);

	// Gearbox state
	logic rx_valid;
	logic [eth_rx_pkg::GEAR_CNT_W-1:0] rx_count;
	logic [eth_rx_pkg::GEAR_W-1:0] rx_gears;
	logic [eth_rx_pkg::GEAR_W+eth_rx_pkg::WORD_W-1:0] full_set;

	// Aligner state
	logic [eth_rx_pkg::BLOCK_W-1:0] al_last;
	logic [eth_rx_pkg::BLOCK_W-1:0] al_data;
	logic [2*eth_rx_pkg::BLOCK_W-1:0] al_window;
	logic [eth_rx_pkg::SLIP_W-1:0] al_shift;
	logic al_slip;
	logic hdr_good;

	// Lock hysteresis
	logic [eth_rx_pkg::LOCK_CNT_W-1:0] lock_count;

	////////////////////
	// Gearbox
	////////////////////

	// Bits held = 2 * rx_count
	// Strobe once 66 or more are held
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			rx_count <= '0;
			rx_valid <= 1'b0;
		end
		else if (rx_valid)
		begin
			// Net change is +32 - 33 pairs
			rx_count <= rx_count - 1'b1;
			rx_valid <= (rx_count > eth_rx_pkg::GEAR_FULL);
		end
		else
		begin
			rx_count <= rx_count + eth_rx_pkg::GEAR_ADD;
			rx_valid <= (rx_count + eth_rx_pkg::GEAR_ADD >= eth_rx_pkg::GEAR_FULL);
		end
	end

	// New word lands just above the held bits
	always_comb
	begin
		full_set = {{eth_rx_pkg::WORD_W{1'b0}}, rx_gears}
			| ({{eth_rx_pkg::GEAR_W{1'b0}}, i_word} << {rx_count, 1'b0});
		// Drop the block being handed on
		if (rx_valid)
			full_set = full_set >> eth_rx_pkg::BLOCK_W;
	end

	// Bits above the fill level must stay zero for the OR merge
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			rx_gears <= '0;
		else
			rx_gears <= full_set[eth_rx_pkg::GEAR_W-1:0];
	end

	////////////////////
	// Alignment
	////////////////////

	// Two raw blocks back to back, oldest in the low half
	assign al_window = {rx_gears[eth_rx_pkg::BLOCK_W-1:0], al_last} >> al_shift;

	always_ff @(posedge i_clk)
	begin
		if (rx_valid)
		begin
			al_last <= rx_gears[eth_rx_pkg::BLOCK_W-1:0];
			al_data <= al_window[eth_rx_pkg::BLOCK_W-1:0];
		end
	end

	// Only 01 and 10 are legal sync headers
	assign hdr_good = al_data[0] ^ al_data[1];

	////////////////////
	// Lock and slip
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			lock_count <= '0;
			al_slip <= 1'b0;
			al_shift <= '0;
		end
		else if (rx_valid)
		begin
			if (al_slip)
			begin
				// al_data still holds the old offset this strobe
				al_slip <= 1'b0;
			end
			else if (hdr_good)
			begin
				if (lock_count != eth_rx_pkg::LOCK_MAX)
					lock_count <= lock_count + 1'b1;
			end
			else if (lock_count > eth_rx_pkg::LOCK_PENALTY)
			begin
				lock_count <= lock_count - eth_rx_pkg::LOCK_PENALTY;
			end
			else
			begin
				// Give up on this offset, try the next bit
				lock_count <= '0;
				al_slip <= 1'b1;
				if (al_shift == eth_rx_pkg::SLIP_LAST)
					al_shift <= '0;
				else
					al_shift <= al_shift + 1'b1;
			end
		end
	end

	////////////////////
	// Outputs
	////////////////////
	assign o_locked = lock_count[eth_rx_pkg::LOCK_BIT];
	assign o_valid = rx_valid && lock_count[eth_rx_pkg::LOCK_BIT];
	// Header first on the wire, payload above it
	assign o_block.hdr = al_data[1:0];
	assign o_block.payload = al_data[eth_rx_pkg::BLOCK_W-1:2];

endmodule

//--- rtl/rx_descramble_bank.sv
/* Self-synchronous 64b/66b descramblers, one per port, with registered lock
   status lined up against the descrambled blocks */
`timescale 1ns/1ns

module rx_descramble_bank
(
	input logic i_clk,
	input logic i_reset,
	input logic [eth_rx_pkg::NUM_PORTS-1:0] i_valid,
	input eth_rx_pkg::rx_block_t [eth_rx_pkg::NUM_PORTS-1:0] i_block,
	input logic [eth_rx_pkg::NUM_PORTS-1:0] i_locked,
	output logic [eth_rx_pkg::NUM_PORTS-1:0] o_valid,
	output eth_rx_pkg::rx_block_t [eth_rx_pkg::NUM_PORTS-1:0] o_block,
	output logic [eth_rx_pkg::NUM_PORTS-1:0] o_lock
);

	// Bit k-1 of the history is the scrambled bit received k bits ago
	logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::SCR_TAP_B-1:0] hist_q;
	logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::SCR_TAP_B-1:0] hist_d;
	logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] plain;

	////////////////////
	// Descramble
	////////////////////
	always_comb
	begin
		logic [eth_rx_pkg::SCR_TAP_B-1:0] hist;
		hist = '0;
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			hist = hist_q[p];
			// LSB goes out first, so walk upward
			for (int b = 0; b < eth_rx_pkg::WORD_W; b++)
			begin
				plain[p][b] = i_block[p].payload[b]
					^ hist[eth_rx_pkg::SCR_TAP_A-1]
					^ hist[eth_rx_pkg::SCR_TAP_B-1];
				// History takes the scrambled bit, not the plain one
				hist = {hist[eth_rx_pkg::SCR_TAP_B-2:0], i_block[p].payload[b]};
			end
			hist_d[p] = hist;
		end
	end

	////////////////////
	// Registers
	////////////////////
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid <= '0;
			o_lock <= '0;
			hist_q <= '0;
		end
		else
		begin
			o_valid <= i_valid;
			// Same delay as the data path
			o_lock <= i_locked;
			for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
			begin
				if (i_valid[p])
					hist_q[p] <= hist_d[p];
			end
		end
	end

	// Block payload, held between strobes
	always_ff @(posedge i_clk)
	begin
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			if (i_valid[p])
			begin
				// Header is not scrambled
				o_block[p].hdr <= i_block[p].hdr;
				o_block[p].payload <= plain[p];
			end
		end
	end

endmodule

//--- rtl/eth_rx_top.sv
/* Four-port 10GBASE-R receive front end. Serdes words in, lane remap,
   per-port gearbox and block lock, then descrambled blocks out */
`timescale 1ns/1ns

module eth_rx_top
(
	input logic i_clk,
	input logic i_reset,
	input logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] i_serdes,
	input eth_rx_pkg::lane_map_t i_lane_map,
	input logic [eth_rx_pkg::NUM_PORTS-1:0] i_polarity,
	output logic [eth_rx_pkg::NUM_PORTS-1:0] o_valid,
	output eth_rx_pkg::rx_block_t [eth_rx_pkg::NUM_PORTS-1:0] o_block,
	output logic [eth_rx_pkg::NUM_PORTS-1:0] o_lock
);

	// Remapped words, one per logical port
	logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] port_words;

	// Aligner outputs
	logic [eth_rx_pkg::NUM_PORTS-1:0] al_valid;
	eth_rx_pkg::rx_block_t [eth_rx_pkg::NUM_PORTS-1:0] al_block;
	logic [eth_rx_pkg::NUM_PORTS-1:0] al_locked;

	////////////////////
	// Lane remap
	////////////////////
	rx_lane_remap u_remap
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_serdes(i_serdes),
		.i_lane_map(i_lane_map),
		.i_polarity(i_polarity),
		.o_words(port_words)
	);

	// One gearbox and aligner per logical port
	generate
		for (genvar p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin : g_port
			rx_gearbox_align u_align
			(
				.i_clk(i_clk),
				.i_reset(i_reset),
				.i_word(port_words[p]),
				.o_valid(al_valid[p]),
				.o_block(al_block[p]),
				.o_locked(al_locked[p])
			);
		end
	endgenerate

	////////////////////
	// Descramblers
	////////////////////
	rx_descramble_bank u_descr
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_valid(al_valid),
		.i_block(al_block),
		.i_locked(al_locked),
		.o_valid(o_valid),
		.o_block(o_block),
		.o_lock(o_lock)
	);

endmodule

//--- verification/tb_clkgen.sv
/* Clock and reset source for the eth_rx testbench. 4 ns clock, synchronous
   reset held high for the first 10 rising edges */
`timescale 1ns/1ns

module tb_clkgen
(
	output logic o_clk,
	output logic o_reset
);

	localparam int HALF_PERIOD_NS = 2;
	localparam int RESET_CYCLES = 10;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD_NS) o_clk = ~o_clk;
	end

	// Released on a rising edge, like every other driven input
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

//--- verification/tb_eth_rx.sv
/* Testbench for eth_rx_top. Scrambles and serializes random blocks per port,
   shuffles them onto serdes lanes, then checks lock and in-order delivery */
`timescale 1ns/1ns

module tb_eth_rx;

	localparam int N_WORDS = 6000;
	localparam int CLK_PERIOD_NS = 4;
	localparam int WATCHDOG_NS = (N_WORDS + 2000) * CLK_PERIOD_NS;
	localparam int LOCK_LIMIT = 66 * 40;
	localparam int CORRUPT_PORT = 2;
	localparam int CORRUPT_WORD = 2000;
	localparam int CORRUPT_LEN = 8;
	localparam int MIN_BLOCKS = 1000;
	localparam int MIN_RELOCK_BLOCKS = 200;
	localparam int SEED = 47363;
	// Serial backlog, under one word plus one block
	localparam int TX_W = 192;
	// Counter 15 to 12 to 9 to 6, so lock goes after the third bad header
	localparam int BAD_HDRS_TO_LOSE = 3;
	// First block after lock has stale history, the second must match
	localparam int SYNC_BLOCK = 2;

	logic i_clk;
	logic i_reset;
	logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] i_serdes;
	eth_rx_pkg::lane_map_t i_lane_map;
	logic [eth_rx_pkg::NUM_PORTS-1:0] i_polarity;
	logic [eth_rx_pkg::NUM_PORTS-1:0] o_valid;
	eth_rx_pkg::rx_block_t [eth_rx_pkg::NUM_PORTS-1:0] o_block;
	logic [eth_rx_pkg::NUM_PORTS-1:0] o_lock;

	////////////////////
	// Transmit model state
	////////////////////
	logic [31:0] rng_state;
	eth_rx_pkg::lane_map_t lane_map;
	logic [eth_rx_pkg::NUM_PORTS-1:0] polarity;
	// Bit k-1 is the scrambled bit sent k bits ago
	logic [eth_rx_pkg::SCR_TAP_B-1:0] scr_state [eth_rx_pkg::NUM_PORTS];
	// Bit 0 goes on the wire first
	logic [TX_W-1:0] tx_bits [eth_rx_pkg::NUM_PORTS];
	int tx_cnt [eth_rx_pkg::NUM_PORTS];
	int blocks_sent [eth_rx_pkg::NUM_PORTS];
	eth_rx_pkg::rx_block_t sent_q [eth_rx_pkg::NUM_PORTS][$];
	int corrupt_left;
	logic corrupt_started;

	// Checker state
	logic [eth_rx_pkg::NUM_PORTS-1:0] synced;
	logic [eth_rx_pkg::NUM_PORTS-1:0] wait_loss;
	logic [eth_rx_pkg::NUM_PORTS-1:0] lock_seen;
	logic [eth_rx_pkg::NUM_PORTS-1:0] late_flag;
	logic [eth_rx_pkg::NUM_PORTS-1:0] lost_lock;
	int matched [eth_rx_pkg::NUM_PORTS];
	int discarded [eth_rx_pkg::NUM_PORTS];
	int relock_matched [eth_rx_pkg::NUM_PORTS];
	// Blocks delivered since lock rose, while hunting
	int since_lock [eth_rx_pkg::NUM_PORTS];
	int bad_delivered;
	int mismatch_errors;
	int other_errors;

	tb_clkgen u_clkgen
	(
		.o_clk(i_clk),
		.o_reset(i_reset)
	);

	eth_rx_top i_dut
	(
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_serdes(i_serdes),
		.i_lane_map(i_lane_map),
		.i_polarity(i_polarity),
		.o_valid(o_valid),
		.o_block(o_block),
		.o_lock(o_lock)
	);

	////////////////////
	// Random source
	////////////////////
	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = xorshift32();
		lo = xorshift32();
		return {hi, lo};
	endfunction

	// Transmit scrambler, s = d ^ s[-39] ^ s[-58], LSB first
	function automatic logic [eth_rx_pkg::WORD_W-1:0] scramble(input int p,
		input logic [eth_rx_pkg::WORD_W-1:0] data);
		logic [eth_rx_pkg::SCR_TAP_B-1:0] st;
		logic [eth_rx_pkg::WORD_W-1:0] s;
		st = scr_state[p];
		for (int b = 0; b < eth_rx_pkg::WORD_W; b++)
		begin
			s[b] = data[b] ^ st[eth_rx_pkg::SCR_TAP_A-1] ^ st[eth_rx_pkg::SCR_TAP_B-1];
			st = {st[eth_rx_pkg::SCR_TAP_B-2:0], s[b]};
		end
		scr_state[p] = st;
		return s;
	endfunction

	// Random lane permutation, never the identity, with mixed polarity
	task automatic pick_lane_config();
		logic [31:0] r;
		int j;
		logic [eth_rx_pkg::LANE_IDX_W-1:0] tmp;
		logic ident;
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
			lane_map[p] = eth_rx_pkg::LANE_IDX_W'(p);
		for (int i = eth_rx_pkg::NUM_PORTS - 1; i > 0; i--)
		begin
			r = xorshift32();
			j = int'(r % 32'(i + 1));
			tmp = lane_map[i];
			lane_map[i] = lane_map[j];
			lane_map[j] = tmp;
		end
		ident = 1'b1;
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
			if (int'(lane_map[p]) != p)
				ident = 1'b0;
		if (ident)
			for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
				lane_map[p] = eth_rx_pkg::LANE_IDX_W'((p + 1) % eth_rx_pkg::NUM_PORTS);
		r = xorshift32();
		polarity = r[eth_rx_pkg::NUM_PORTS-1:0];
		if (polarity == '0 || polarity == '1)
			polarity = polarity ^ {eth_rx_pkg::NUM_PORTS/2{2'b01}};
	endtask

	task automatic init_model();
		logic [31:0] r;
		logic [63:0] v;
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			v = rand64();
			scr_state[p] = v[eth_rx_pkg::SCR_TAP_B-1:0];
			// Junk lead-in of 0 to 65 bits puts blocks at a random offset
			r = xorshift32();
			tx_cnt[p] = int'(r % 32'd66);
			v = rand64();
			tx_bits[p] = TX_W'(v);
			blocks_sent[p] = 0;
			matched[p] = 0;
			discarded[p] = 0;
			relock_matched[p] = 0;
			since_lock[p] = 0;
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////
	task automatic make_block(input int p);
		eth_rx_pkg::rx_block_t blk;
		logic [31:0] r;
		logic [eth_rx_pkg::WORD_W-1:0] scr;
		r = xorshift32();
		blk.hdr = r[0] ? 2'b10 : 2'b01;
		if (p == CORRUPT_PORT && corrupt_left > 0)
		begin
			blk.hdr = 2'b00;
			corrupt_left--;
		end
		blk.payload = rand64();
		sent_q[p].push_back(blk);
		scr = scramble(p, blk.payload);
		// Header bits lead, header bit 0 first
		tx_bits[p][tx_cnt[p] +: eth_rx_pkg::BLOCK_W] = {scr, blk.hdr};
		tx_cnt[p] = tx_cnt[p] + eth_rx_pkg::BLOCK_W;
		blocks_sent[p]++;
	endtask

	task automatic drive_words();
		logic [eth_rx_pkg::NUM_PORTS-1:0][eth_rx_pkg::WORD_W-1:0] lanes;
		logic [eth_rx_pkg::WORD_W-1:0] word;
		int lane;
		lanes = '0;
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			if (tx_cnt[p] < eth_rx_pkg::WORD_W)
				make_block(p);
			word = tx_bits[p][eth_rx_pkg::WORD_W-1:0];
			tx_bits[p] = tx_bits[p] >> eth_rx_pkg::WORD_W;
			tx_cnt[p] = tx_cnt[p] - eth_rx_pkg::WORD_W;
			// Port p travels on physical lane map[p]
			lane = int'(lane_map[p]);
			lanes[lane] = word ^ {eth_rx_pkg::WORD_W{polarity[lane]}};
		end
		i_serdes <= lanes;
	endtask

	////////////////////
	// Checks
	////////////////////
	task automatic check_block(input int p, input eth_rx_pkg::rx_block_t exp_blk,
		input eth_rx_pkg::rx_block_t act_blk);
		if (act_blk !== exp_blk)
		begin
			mismatch_errors++;
			$display("mismatch o_block[%0d] exp %h act %h", p, exp_blk, act_blk);
		end
	endtask

	task automatic check_lock(input logic [eth_rx_pkg::NUM_PORTS-1:0] exp_mask,
		input logic [eth_rx_pkg::NUM_PORTS-1:0] act_mask,
		input logic [eth_rx_pkg::NUM_PORTS-1:0] care);
		if ((act_mask & care) !== (exp_mask & care))
		begin
			mismatch_errors++;
			$display("mismatch o_lock exp %h act %h", exp_mask & care, act_mask & care);
		end
	endtask

	// In sync, blocks come in order; hunting, look for the block in the queue
	task automatic match_block(input int p, input eth_rx_pkg::rx_block_t blk);
		eth_rx_pkg::rx_block_t exp_blk;
		int hit;
		hit = -1;
		if (synced[p])
		begin
			if (sent_q[p].size() == 0)
			begin
				other_errors++;
				$display("port %0d delivered a block that was never sent", p);
			end
			else
			begin
				exp_blk = sent_q[p].pop_front();
				check_block(p, exp_blk, blk);
				matched[p]++;
				if (wait_loss[p] && exp_blk.hdr == 2'b00)
					bad_delivered++;
				if (lost_lock[p])
					relock_matched[p]++;
			end
		end
		else
		begin
			since_lock[p]++;
			for (int i = 0; i < sent_q[p].size(); i++)
				if (hit < 0 && sent_q[p][i] == blk)
					hit = i;
			// Stale descrambler history spoils the first block, so skip it
			if (hit < 0)
				discarded[p]++;
			else
			begin
				if (since_lock[p] != SYNC_BLOCK)
				begin
					other_errors++;
					$display("port %0d first matched block %0d after lock, not block %0d",
						p, since_lock[p], SYNC_BLOCK);
				end
				for (int i = 0; i <= hit; i++)
					exp_blk = sent_q[p].pop_front();
				synced[p] = 1'b1;
				matched[p]++;
			end
		end
	endtask

	task automatic sample_outputs();
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			if (o_lock[p])
				lock_seen[p] = 1'b1;
			else if (!lock_seen[p] && !late_flag[p] && blocks_sent[p] > LOCK_LIMIT)
			begin
				late_flag[p] = 1'b1;
				other_errors++;
				$display("port %0d did not lock within %0d blocks", p, LOCK_LIMIT);
			end
			if (!o_lock[p])
				since_lock[p] = 0;
			if (wait_loss[p] && !o_lock[p])
			begin
				wait_loss[p] = 1'b0;
				synced[p] = 1'b0;
				lost_lock[p] = 1'b1;
				if (bad_delivered != BAD_HDRS_TO_LOSE)
				begin
					other_errors++;
					$display("port %0d lost lock after %0d bad headers, not %0d",
						p, bad_delivered, BAD_HDRS_TO_LOSE);
				end
			end
			if (o_valid[p] && !o_lock[p])
			begin
				other_errors++;
				$display("port %0d delivered a block while not locked", p);
			end
			if (o_valid[p])
				match_block(p, o_block[p]);
		end
		check_lock('1, o_lock, synced & ~wait_loss);
		// A port that drops lock goes back to hunting
		synced = synced & (o_lock | wait_loss);
	endtask

	task automatic final_checks();
		check_lock('1, o_lock, '1);
		if (!corrupt_started)
		begin
			other_errors++;
			$display("header corruption never ran, not all ports were in sync");
		end
		for (int p = 0; p < eth_rx_pkg::NUM_PORTS; p++)
		begin
			$display("port %0d: lane %0d inverted %0b checked %0d skipped %0d", p,
				lane_map[p], polarity[lane_map[p]], matched[p], discarded[p]);
			if (matched[p] < MIN_BLOCKS)
			begin
				other_errors++;
				$display("port %0d delivered only %0d checked blocks", p, matched[p]);
			end
		end
		if (!lost_lock[CORRUPT_PORT])
		begin
			other_errors++;
			$display("port %0d kept lock through the bad headers", CORRUPT_PORT);
		end
		else if (relock_matched[CORRUPT_PORT] < MIN_RELOCK_BLOCKS)
		begin
			other_errors++;
			$display("port %0d did not relock and resume delivery", CORRUPT_PORT);
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin
		rng_state = SEED;
		i_serdes = '0;
		i_lane_map = '0;
		i_polarity = '0;
		synced = '0;
		wait_loss = '0;
		lock_seen = '0;
		late_flag = '0;
		lost_lock = '0;
		corrupt_left = 0;
		corrupt_started = 1'b0;
		bad_delivered = 0;
		mismatch_errors = 0;
		other_errors = 0;
		pick_lane_config();
		init_model();
		@(posedge i_clk);
		i_lane_map <= lane_map;
		i_polarity <= polarity;
		while (i_reset)
			@(posedge i_clk);
		for (int w = 0; w < N_WORDS; w++)
		begin
			@(posedge i_clk);
			sample_outputs();
			// Burst of 00 headers once every port delivers in order
			if (!corrupt_started && (&synced) && w >= CORRUPT_WORD)
			begin
				corrupt_started = 1'b1;
				corrupt_left = CORRUPT_LEN;
				wait_loss[CORRUPT_PORT] = 1'b1;
			end
			drive_words();
		end
		final_checks();
		$display("errors: %0d mismatch, %0d other", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Run length plus margin, in case a port stalls the sequence
	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- eth_rx.f
rtl/eth_rx_pkg.sv
rtl/rx_lane_remap.sv
rtl/rx_gearbox_align.sv
rtl/rx_descramble_bank.sv
rtl/eth_rx_top.sv
verification/tb_clkgen.sv
verification/tb_eth_rx.sv

//--- Makefile
# Verilator build of the eth_rx testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP ?= tb_eth_rx
FLIST ?= eth_rx.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ns

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result, not the simulator exit code
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "No result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
